/* sources.f */
design/telem_pkg.sv
design/pack_if.sv
design/async_fifo.sv
design/word_packer.sv
design/sync_fifo.sv
design/telem_packer_top.sv
testbench/tb_telem_packer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the telemetry packer simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_telem_packer -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out="$(./obj_dir/sim_tb)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Result: PASSED"; then
    exit 0
else
    exit 1
fi

/* testbench/tb_telem_packer.sv */
// Testbench for the telemetry sample packer
// Queue model of accepted samples, assertions on every word read,
// back-pressure, underflow and random gap runs
`timescale 1ns/1ns
`default_nettype none

module tb_telem_packer;
    import telem_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int SRC_PERIOD = 60;
    localparam int DRIVE_DLY  = 5;
    localparam int SEED       = 32'h5642ec1f;
    // Sample counts per test, burst counts are write attempts
    localparam int N_ORDER    = 48;
    localparam int N_FRAME    = 32;
    localparam int N_BP       = 64;
    localparam int N_RAND     = 96;
    localparam int N_TOTAL    = N_ORDER + N_FRAME + N_BP + N_RAND + LANES;
    localparam int WATCHDOG_NS = N_TOTAL * 8 * SRC_PERIOD + 20000;
    // Samples the pipeline can hold with the reader stopped
    localparam int CAPACITY   = CDC_DEPTH + LANES + OUT_DEPTH * LANES;
    // Empty buffer cycles before a drain stops waiting
    localparam int DRAIN_IDLE = 64;

    logic                   src_clk;
    logic                   clk;
    logic                   rrst;
    logic                   sample_valid;
    logic [SAMPLE_BITS-1:0] sample_data;
    logic                   sample_full;
    logic                   out_ren;
    logic [WORD_BITS-1:0]   out_data;
    logic                   out_first;
    logic                   out_empty;
    logic                   out_rerror;

    // Accepted samples not yet seen in a word
    logic [SAMPLE_BITS-1:0] q [$];
    integer seed     = SEED;
    integer gap_seed = SEED;
    int     errors   = 0;
    int     n_pass   = 0;
    int     n_fail   = 0;
    int     word_idx = 0;
    int     first_seen = 0;
    // Reader mode: 0 stopped, 1 always, 2 random gaps, 3 driven by the test
    int     rd_mode  = 3;
    logic   bp_active = 1'b0;
    int     bp_count = 0;
    logic   saw_full = 1'b0;

    telem_packer_top dut_i (
        .src_clk      (src_clk),
        .clk          (clk),
        .rrst         (rrst),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .sample_full  (sample_full),
        .out_ren      (out_ren),
        .out_data     (out_data),
        .out_first    (out_first),
        .out_empty    (out_empty),
        .out_rerror   (out_rerror)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        src_clk = 1'b0;
        forever #(SRC_PERIOD / 2) src_clk = ~src_clk;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

    // ============================================================
    // Source monitor, write counts when full is low at the edge
    // ============================================================
    initial begin
        forever begin
            @(negedge src_clk);
            if (!rrst && sample_valid && !sample_full) begin
                q.push_back(sample_data);
                if (bp_active) begin
                    bp_count++;
                    assert (bp_count <= CAPACITY) else begin
                        $display("more samples accepted than the pipeline can hold");
                        errors++;
                    end
                end
            end
            if (bp_active && sample_full) begin
                saw_full = 1'b1;
            end
        end
    end

    // Reader strobe
    initial begin
        logic [31:0] r;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            if (rd_mode == 0) begin
                out_ren = 1'b0;
            end else if (rd_mode == 1) begin
                out_ren = 1'b1;
            end else if (rd_mode == 2) begin
                r = $random(gap_seed);
                out_ren = r[0];
            end
        end
    end

    // ============================================================
    // Output checker, samples on the falling clk edge
    // ============================================================
    initial begin
        logic                 read_taken;
        logic [WORD_BITS-1:0] last_data;
        logic                 last_first;
        logic [WORD_BITS-1:0] exp;
        logic                 exp_first;
        read_taken = 1'b0;
        forever begin
            @(negedge clk);
            if (rrst) begin
                read_taken = 1'b0;
            end else begin
                if (read_taken) begin
                    assert (q.size() >= LANES) else begin
                        $display("a word was read before four samples were written");
                        errors++;
                    end
                    if (q.size() >= LANES) begin
                        // Lane 0 is the oldest sample
                        for (int i = 0; i < LANES; i++) begin
                            exp[i*SAMPLE_BITS +: SAMPLE_BITS] = q.pop_front();
                        end
                        assert (out_data == exp) else begin
                            $display("error: out_data %h, expected %h", out_data, exp);
                            errors++;
                        end
                    end
                    exp_first = (word_idx % FRAME_WORDS == 0);
                    assert (out_first == exp_first) else begin
                        $display("error: out_first %h, expected %h", out_first, exp_first);
                        errors++;
                    end
                    if (out_first) begin
                        first_seen++;
                    end
                    word_idx++;
                end else begin
                    // No read accepted, outputs hold
                    assert (out_data == last_data && out_first == last_first) else begin
                        $display("error: out_data %h, expected %h held", out_data, last_data);
                        errors++;
                    end
                end
                assert (out_rerror == (out_ren && out_empty)) else begin
                    $display("error: out_rerror %h, expected %h",
                             out_rerror, out_ren && out_empty);
                    errors++;
                end
                read_taken = out_ren && !out_empty;
            end
            last_data  = out_data;
            last_first = out_first;
        end
    end

    // One sample, held until the FIFO takes it
    task automatic write_sample(input logic [SAMPLE_BITS-1:0] data);
        @(posedge src_clk);
        #DRIVE_DLY;
        sample_valid = 1'b1;
        sample_data  = data;
        @(negedge src_clk);
        while (sample_full) begin
            @(negedge src_clk);
        end
        @(posedge src_clk);
        #DRIVE_DLY;
        sample_valid = 1'b0;
    endtask

    // Write attempts every src_clk cycle, full writes get dropped
    task automatic write_burst(input int n, input logic gaps);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            @(posedge src_clk);
            #DRIVE_DLY;
            r = $random(seed);
            sample_data  = r[SAMPLE_BITS-1:0];
            sample_valid = gaps ? r[SAMPLE_BITS] : 1'b1;
        end
        @(posedge src_clk);
        #DRIVE_DLY;
        sample_valid = 1'b0;
    endtask

    task automatic write_random(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            write_sample(r[SAMPLE_BITS-1:0]);
        end
    endtask

    // Top up to whole words so nothing stays in the packer
    task automatic pad_to_word;
        logic [31:0] r;
        while (q.size() % LANES != 0) begin
            r = $random(seed);
            write_sample(r[SAMPLE_BITS-1:0]);
        end
    endtask

    // Reader must be running
    // Gives up once the buffer stays empty for DRAIN_IDLE cycles
    task automatic drain_and_check;
        int idle;
        idle = 0;
        @(negedge clk);
        while ((q.size() >= LANES || !out_empty) && idle < DRAIN_IDLE) begin
            @(negedge clk);
            if (out_empty) begin
                idle++;
            end else begin
                idle = 0;
            end
        end
        repeat (2) @(negedge clk);
        assert (q.size() == 0) else begin
            $display("accepted samples were not all delivered");
            errors++;
        end
    endtask

    task automatic check_idle;
        assert (!sample_full) else begin
            $display("error: sample_full %h, expected 0", sample_full);
            errors++;
        end
        assert (out_empty) else begin
            $display("error: out_empty %h, expected 1", out_empty);
            errors++;
        end
        assert (!out_first) else begin
            $display("error: out_first %h, expected 0", out_first);
            errors++;
        end
        assert (out_data == '0) else begin
            $display("error: out_data %h, expected 0", out_data);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) begin
            n_pass++;
            $display("test %-16s ok", name);
        end else begin
            n_fail++;
            $display("test %-16s failed with %0d errors", name, errors - err_start);
        end
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        int err_start;
        int first_start;
        logic [WORD_BITS-1:0] held;
        rrst         = 1'b1;
        sample_valid = 1'b0;
        sample_data  = '0;
        out_ren      = 1'b0;

        // 1. Reset state, inside reset and just after release
        err_start = errors;
        repeat (15) @(posedge clk);
        @(negedge clk);
        check_idle();
        @(posedge clk);
        #DRIVE_DLY;
        rrst = 1'b0;
        @(negedge clk);
        check_idle();
        report_test("reset state", err_start);

        // 2. Packing order, reader always on
        err_start = errors;
        rd_mode = 1;
        write_random(N_ORDER);
        drain_and_check();
        report_test("packing order", err_start);

        // 3. Frame marking, starts on a frame boundary
        err_start   = errors;
        first_start = first_seen;
        write_random(N_FRAME);
        drain_and_check();
        assert (first_seen - first_start == N_FRAME / (LANES * FRAME_WORDS)) else begin
            $display("wrong number of frame-first words seen");
            errors++;
        end
        report_test("frame marking", err_start);

        // 4. Back-pressure, reader stopped, source writes nonstop
        err_start = errors;
        rd_mode   = 0;
        bp_count  = 0;
        saw_full  = 1'b0;
        bp_active = 1'b1;
        write_burst(N_BP, 1'b0);
        bp_active = 1'b0;
        assert (saw_full) else begin
            $display("sample_full never rose while the reader was stopped");
            errors++;
        end
        rd_mode = 1;
        pad_to_word();
        drain_and_check();
        report_test("back-pressure", err_start);

        // 5. Underflow, one strobe on an empty buffer
        err_start = errors;
        rd_mode   = 3;
        @(posedge clk);
        #DRIVE_DLY;
        out_ren = 1'b1;
        @(negedge clk);
        held = out_data;
        assert (out_empty) else begin
            $display("error: out_empty %h, expected 1", out_empty);
            errors++;
        end
        assert (out_rerror) else begin
            $display("error: out_rerror %h, expected 1", out_rerror);
            errors++;
        end
        @(posedge clk);
        #DRIVE_DLY;
        out_ren = 1'b0;
        @(negedge clk);
        assert (out_data == held) else begin
            $display("error: out_data %h, expected %h", out_data, held);
            errors++;
        end
        report_test("underflow", err_start);

        // 6. Random gaps on both sides
        err_start = errors;
        rd_mode   = 2;
        write_burst(N_RAND, 1'b1);
        pad_to_word();
        drain_and_check();
        report_test("random gaps", err_start);

        $display("tests: %0d ok, %0d failed, %0d errors, %0d words checked",
                 n_pass, n_fail, errors, word_idx);
        if (errors == 0 && n_fail == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/telem_packer_top.sv */
// Telemetry sample packer top
// src_clk samples cross to clk, are packed four to a word,
// and are buffered for a strobe-driven reader
`timescale 1ns/1ns
`default_nettype none

module telem_packer_top (
    input  logic                              src_clk,
    input  logic                              clk,
    input  logic                              rrst,
    // Source side, src_clk
    input  logic                              sample_valid,
    input  logic [telem_pkg::SAMPLE_BITS-1:0] sample_data,
    output logic                              sample_full,
    // Reader side, clk
    input  logic                              out_ren,
    output logic [telem_pkg::WORD_BITS-1:0]   out_data,
    output logic                              out_first,
    output logic                              out_empty,
    output logic                              out_rerror
);
    import telem_pkg::*;

    // Crossing FIFO to packer
    logic [SAMPLE_BITS-1:0] smp_data;
    logic                   smp_empty;
    logic                   smp_ren;
    // Buffer entry, flag on top
    logic [WORD_BITS:0]     out_entry;

    pack_if pk_if ();

    // One reset clears both domains
    async_fifo #(
        .DATA_BIT (SAMPLE_BITS),
        .DEPTH    (CDC_DEPTH)
    ) cdc_fifo_i (
        .wclk   (src_clk),
        .wrst   (rrst),
        .wen    (sample_valid),
        .wdata  (sample_data),
        .wfull  (sample_full),
        .rclk   (clk),
        .rrst   (rrst),
        .ren    (smp_ren),
        .rdata  (smp_data),
        .rempty (smp_empty)
    );

    word_packer packer_i (
        .clk    (clk),
        .rrst   (rrst),
        .rdata  (smp_data),
        .rempty (smp_empty),
        .ren    (smp_ren),
        .out    (pk_if.packer)
    );

    sync_fifo #(
        .DATA_BIT (WORD_BITS),
        .DEPTH    (OUT_DEPTH)
    ) out_fifo_i (
        .clk    (clk),
        .rrst   (rrst),
        .in     (pk_if.buffer),
        .ren    (out_ren),
        .rdata  (out_entry),
        .rempty (out_empty),
        .rerror (out_rerror)
    );

    // Split stored flag from the word
    assign out_data  = out_entry[WORD_BITS-1:0];
    assign out_first = out_entry[WORD_BITS];

endmodule

`default_nettype wire

/* design/sync_fifo.sv */
// Output buffer
// Single-clock FIFO of packed words, each stored with its first flag
// as one extra top bit; occupancy count drives the flags
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
    parameter int DATA_BIT = 64,
    parameter int DEPTH    = 8
) (
    input  logic              clk,
    input  logic              rrst,
    // Write side from the packer
    pack_if.buffer            in,
    // Read side, flag in the top bit
    input  logic              ren,
    output logic [DATA_BIT:0] rdata,
    output logic              rempty,
    output logic              rerror
);

    localparam int ADDR_BIT = $clog2(DEPTH);

    logic [DATA_BIT:0]   mem [DEPTH];
    logic [ADDR_BIT-1:0] waddr;
    logic [ADDR_BIT-1:0] raddr;
    logic [ADDR_BIT:0]   count;
    logic                do_wr;
    logic                do_rd;

    assign do_wr = in.wen & ~in.wfull;
    assign do_rd = ren & ~rempty;

    // ============================================================
    // Flags
    // ============================================================
    assign in.wfull = (count == (ADDR_BIT + 1)'(DEPTH));
    assign rempty   = (count == '0);
    // Read attempt with nothing stored
    assign rerror   = ren & rempty;

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[waddr] <= {in.wfirst, in.wdata};
        end
    end

    // Read register, cleared so the first flag starts low
    always_ff @(posedge clk or posedge rrst) begin
        if (rrst) begin
            rdata <= '0;
        end else if (do_rd) begin
            rdata <= mem[raddr];
        end
    end

    // Addresses wrap at DEPTH, any depth works
    always_ff @(posedge clk or posedge rrst) begin
        if (rrst) begin
            waddr <= '0;
            raddr <= '0;
        end else begin
            if (do_wr) begin
                waddr <= (waddr == ADDR_BIT'(DEPTH - 1)) ? '0 : waddr + 1'b1;
            end
            if (do_rd) begin
                raddr <= (raddr == ADDR_BIT'(DEPTH - 1)) ? '0 : raddr + 1'b1;
            end
        end
    end

    // Occupancy, unchanged on simultaneous read and write
    always_ff @(posedge clk or posedge rrst) begin
        if (rrst) begin
            count <= '0;
        end else if (do_wr && !do_rd) begin
            count <= count + 1'b1;
        end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/word_packer.sv */
// Sample packer
// Reads four samples from the crossing FIFO into lanes, lowest first,
// and writes the packed word with a frame-first flag to the buffer
`timescale 1ns/1ns
`default_nettype none

module word_packer (
    input  logic                             clk,
    input  logic                             rrst,
    // Crossing FIFO read side
    input  logic [telem_pkg::SAMPLE_BITS-1:0] rdata,
    input  logic                             rempty,
    output logic                             ren,
    // Packed word channel
    pack_if.packer                           out
);
    import telem_pkg::*;

    pack_state_t          state;
    // Reads issued for the current word, 0 to LANES
    logic [LANE_BITS:0]   issue_cnt;
    // Next lane to fill
    logic [LANE_BITS-1:0] fill_cnt;
    // Read accepted last cycle, sample now on rdata
    logic                 pend;
    logic [FRAME_BITS-1:0] frame_cnt;
    logic [WORD_BITS-1:0] lanes;

    // Read only while collecting and lanes are still unclaimed
    assign ren = (state == st_collect) && !rempty &&
                 (issue_cnt < (LANE_BITS + 1)'(LANES));

    // Lanes stay intact through the write cycle
    assign out.wdata  = lanes;
    assign out.wfirst = (frame_cnt == '0);

    // Lane payload
    always_ff @(posedge clk) begin
        if (pend) begin
            lanes[fill_cnt*SAMPLE_BITS +: SAMPLE_BITS] <= rdata;
        end
    end

    // ============================================================
    // Control FSM
    // ============================================================
    always_ff @(posedge clk or posedge rrst) begin
        if (rrst) begin
            state     <= st_collect;
            issue_cnt <= '0;
            fill_cnt  <= '0;
            pend      <= 1'b0;
            out.wen   <= 1'b0;
        end else begin
            pend    <= ren;
            out.wen <= 1'b0;
            case (state)
                st_collect: begin
                    if (ren) begin
                        issue_cnt <= issue_cnt + 1'b1;
                    end
                    if (pend) begin
                        if (fill_cnt == LANE_BITS'(LANES - 1)) begin
                            // Last lane in, word is complete
                            fill_cnt  <= '0;
                            issue_cnt <= '0;
                            if (out.wfull) begin
                                state <= st_hold;
                            end else begin
                                out.wen <= 1'b1;
                            end
                        end else begin
                            fill_cnt <= fill_cnt + 1'b1;
                        end
                    end
                end
                st_hold: begin
                    // Wait for buffer room, no reads meanwhile
                    if (!out.wfull) begin
                        out.wen <= 1'b1;
                        state   <= st_collect;
                    end
                end
                default: state <= st_collect;
            endcase
        end
    end

    // Frame position, advances on each written word
    always_ff @(posedge clk or posedge rrst) begin
        if (rrst) begin
            frame_cnt <= '0;
        end else if (out.wen) begin
            if (frame_cnt == FRAME_BITS'(FRAME_WORDS - 1)) begin
                frame_cnt <= '0;
            end else begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/async_fifo.sv */
// Dual-clock FIFO
// Binary pointers address the memory, Gray pointers cross the clocks
// through two flops each; flags are registered in their own domain
`timescale 1ns/1ns
`default_nettype none

module async_fifo #(
    parameter int DATA_BIT = 16,
    parameter int DEPTH    = 16
) (
    // Write side
    input  logic                wclk,
    input  logic                wrst,
    input  logic                wen,
    input  logic [DATA_BIT-1:0] wdata,
    output logic                wfull,
    // Read side
    input  logic                rclk,
    input  logic                rrst,
    input  logic                ren,
    output logic [DATA_BIT-1:0] rdata,
    output logic                rempty
);

    // Address width follows the depth, one extra pointer bit for wrap
    localparam int ADDR_BIT = $clog2(DEPTH);

    logic [DATA_BIT-1:0] mem [DEPTH];

    // Read domain pointers
    logic [ADDR_BIT:0] rbin;
    logic [ADDR_BIT:0] rbin_next;
    logic [ADDR_BIT:0] rgray_next;
    logic [ADDR_BIT:0] rptr;
    logic [ADDR_BIT:0] rq1_wptr;
    logic [ADDR_BIT:0] rq2_wptr;

    // Write domain pointers
    logic [ADDR_BIT:0] wbin;
    logic [ADDR_BIT:0] wbin_next;
    logic [ADDR_BIT:0] wgray_next;
    logic [ADDR_BIT:0] wptr;
    logic [ADDR_BIT:0] wq1_rptr;
    logic [ADDR_BIT:0] wq2_rptr;

    // ============================================================
    // Write domain
    // ============================================================
    assign wbin_next  = wbin + (ADDR_BIT + 1)'(wen & ~wfull);
    assign wgray_next = (wbin_next >> 1) ^ wbin_next;

    // Storage, no reset needed
    always_ff @(posedge wclk) begin
        if (wen && !wfull) begin
            mem[wbin[ADDR_BIT-1:0]] <= wdata;
        end
    end

    always_ff @(posedge wclk or posedge wrst) begin
        if (wrst) begin
            wbin <= '0;
            wptr <= '0;
        end else begin
            wbin <= wbin_next;
            wptr <= wgray_next;
        end
    end

    // Read pointer into write clock
    always_ff @(posedge wclk or posedge wrst) begin
        if (wrst) begin
            wq1_rptr <= '0;
            wq2_rptr <= '0;
        end else begin
            wq1_rptr <= rptr;
            wq2_rptr <= wq1_rptr;
        end
    end

    // Full when write pointer is one lap ahead
    // top two Gray bits differ, rest equal
    always_ff @(posedge wclk or posedge wrst) begin
        if (wrst) begin
            wfull <= 1'b0;
        end else begin
            wfull <= (wgray_next ==
                      {~wq2_rptr[ADDR_BIT:ADDR_BIT-1], wq2_rptr[ADDR_BIT-2:0]});
        end
    end

    // ============================================================
    // Read domain
    // ============================================================
    assign rbin_next  = rbin + (ADDR_BIT + 1)'(ren & ~rempty);
    assign rgray_next = (rbin_next >> 1) ^ rbin_next;

    // Output register, holds until next accepted read
    always_ff @(posedge rclk or posedge rrst) begin
        if (rrst) begin
            rdata <= '0;
        end else if (ren && !rempty) begin
            rdata <= mem[rbin[ADDR_BIT-1:0]];
        end
    end

    always_ff @(posedge rclk or posedge rrst) begin
        if (rrst) begin
            rbin <= '0;
            rptr <= '0;
        end else begin
            rbin <= rbin_next;
            rptr <= rgray_next;
        end
    end

    // Write pointer into read clock
    always_ff @(posedge rclk or posedge rrst) begin
        if (rrst) begin
            rq1_wptr <= '0;
            rq2_wptr <= '0;
        end else begin
            rq1_wptr <= wptr;
            rq2_wptr <= rq1_wptr;
        end
    end

    // Empty once the next read pointer catches the write pointer
    always_ff @(posedge rclk or posedge rrst) begin
        if (rrst) begin
            rempty <= 1'b1;
        end else begin
            rempty <= (rgray_next == rq2_wptr);
        end
    end

endmodule

`default_nettype wire

/* design/pack_if.sv */
// Packed word channel between packer and output buffer
// Word is taken on a clk edge with wen high and wfull low
`timescale 1ns/1ns
`default_nettype none

interface pack_if;
    import telem_pkg::*;

    // One-cycle write strobe from the packer
    logic                 wen;
    // Four samples, lane 0 in the low bits
    logic [WORD_BITS-1:0] wdata;
    // Marks the first word of a frame
    logic                 wfirst;
    // Level from the buffer, no room left
    logic                 wfull;

    // Packer side
    modport packer (
        output wen,
        output wdata,
        output wfirst,
        input  wfull
    );

    // Buffer side
    modport buffer (
        input  wen,
        input  wdata,
        input  wfirst,
        output wfull
    );

endinterface

`default_nettype wire

/* design/telem_pkg.sv */
// Telemetry packer shared definitions
// Sample and word widths, buffer depths, frame length, packer states
`default_nettype none

package telem_pkg;

    // ============================================================
    // Data path widths
    // ============================================================
    localparam int SAMPLE_BITS = 16;
    // Samples joined into one packed word
    localparam int LANES       = 4;
    localparam int WORD_BITS   = SAMPLE_BITS * LANES;
    localparam int LANE_BITS   = $clog2(LANES);

    // ============================================================
    // Framing and buffering
    // ============================================================
    // First word of every frame carries the first flag
    localparam int FRAME_WORDS = 4;
    localparam int FRAME_BITS  = $clog2(FRAME_WORDS);
    // Clock-crossing FIFO, in samples
    localparam int CDC_DEPTH   = 16;
    // Output buffer, in packed words
    localparam int OUT_DEPTH   = 8;

    // Packer FSM
    typedef enum logic {
        st_collect,
        st_hold
    } pack_state_t;

endpackage

`default_nettype wire
